//--- Makefile
TOP = f8_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Ilogic -f f8_mini.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --assert -Ilogic -f f8_mini.f --top-module $(TOP)
	verilator --lint-only --assert -Ilogic -f f8_mini.f --top-module f8_core

clean:
	rm -rf obj_dir

//--- f8_mini.f
+incdir+logic
logic/f8_pkg.sv
logic/f8_alu8.sv
logic/f8_regfile.sv
logic/f8_sequencer.sv
logic/f8_execute.sv
logic/f8_bank_mux.sv
logic/f8_core.sv
verification/f8_mem_model.sv
verification/f8_core_tb.sv

//--- logic/f8_alu8.sv
`include "f8_params.svh"

module f8_alu8 (
	input f8_pkg::alu_op_t op,
	input logic [`F8_DATA_W-1:0] a,
	input logic [`F8_DATA_W-1:0] b,
	input f8_pkg::flags_t carry_in_flags,
	output logic [`F8_DATA_W-1:0] result,
	output f8_pkg::flags_t flags_out
);
	always_comb
	begin
		logic [8:0] sum;
		logic [4:0] low_sum;
		logic [7:0] b_eff;
		logic carry_in;
		// sub is a + ~b + 1, so c set means no borrow
		carry_in = (op == f8_pkg::ALU_SUB);
		b_eff = carry_in ? ~b : b;
		sum = {1'b0, a} + {1'b0, b_eff} + 9'(carry_in);
		low_sum = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + 5'(carry_in);
		flags_out = carry_in_flags;
		case (op)
			f8_pkg::ALU_ADD, f8_pkg::ALU_SUB:
			begin
				result = sum[7:0];
				flags_out.c = sum[8];
				flags_out.h = low_sum[4];
				flags_out.o = (a[7] == b_eff[7]) && (sum[7] != a[7]);
			end
			f8_pkg::ALU_AND: result = a & b;
			f8_pkg::ALU_OR: result = a | b;
			f8_pkg::ALU_XOR: result = a ^ b;
			default: result = a;
		endcase
		flags_out.z = ~|result;
		flags_out.n = result[7];
	end

endmodule

//--- logic/f8_bank_mux.sv
`include "f8_params.svh"

module f8_bank_mux (
	input logic clk,
	input logic [`F8_ADDR_W-1:0] read_addr,
	input f8_pkg::mem_write_t mem_write,
	input logic [`F8_DATA_W-1:0] read_data_even,
	input logic [`F8_DATA_W-1:0] read_data_odd,
	output logic [`F8_BANK_AW-1:0] read_addr_even,
	output logic [`F8_BANK_AW-1:0] read_addr_odd,
	output logic [`F8_BANK_AW-1:0] write_addr_even,
	output logic [`F8_BANK_AW-1:0] write_addr_odd,
	output logic [`F8_DATA_W-1:0] write_data_even,
	output logic [`F8_DATA_W-1:0] write_data_odd,
	output logic write_en_even,
	output logic write_en_odd,
	output logic [`F8_WORD_W-1:0] read_data
);
	// odd start of the read whose data arrives this cycle
	logic read_odd_q;

	// odd start address: the even bank holds the second byte, one word up
	assign read_addr_odd = read_addr[15:1];
	assign read_addr_even = read_addr[15:1] + {14'd0, read_addr[0]};

	always_ff @(posedge clk)
	begin
		read_odd_q <= read_addr[0];
	end

	assign read_data = read_odd_q ? {read_data_even, read_data_odd}
		: {read_data_odd, read_data_even};

	assign write_addr_odd = mem_write.addr[15:1];
	assign write_addr_even = mem_write.addr[15:1] + {14'd0, mem_write.addr[0]};
	assign write_data_even = mem_write.addr[0] ? mem_write.data[15:8] : mem_write.data[7:0];
	assign write_data_odd = mem_write.addr[0] ? mem_write.data[7:0] : mem_write.data[15:8];
	assign write_en_even = mem_write.addr[0] ? mem_write.en[1] : mem_write.en[0];
	assign write_en_odd = mem_write.addr[0] ? mem_write.en[0] : mem_write.en[1];

	a_byte_write_one_bank: assert property (@(posedge clk)
		(mem_write.en == 2'b01) |-> $onehot({write_en_even, write_en_odd}))
		else $error("single byte write did not enable exactly one bank");

endmodule

//--- logic/f8_core.sv
`include "f8_params.svh"

module f8_core (
	input logic clk,
	input logic reset,
	output logic [`F8_BANK_AW-1:0] read_addr_even,
	output logic [`F8_BANK_AW-1:0] read_addr_odd,
	input logic [`F8_DATA_W-1:0] read_data_even,
	input logic [`F8_DATA_W-1:0] read_data_odd,
	output logic [`F8_BANK_AW-1:0] write_addr_even,
	output logic [`F8_BANK_AW-1:0] write_addr_odd,
	output logic [`F8_DATA_W-1:0] write_data_even,
	output logic [`F8_DATA_W-1:0] write_data_odd,
	output logic write_en_even,
	output logic write_en_odd,
	output logic trap
);
	f8_pkg::reg_write_t reg_write;
	f8_pkg::mem_write_t mem_write;
	f8_pkg::flags_t flags;
	f8_pkg::flags_t next_flags;
	logic [`F8_WORD_W-1:0] x;
	logic [`F8_WORD_W-1:0] y;
	logic [`F8_ADDR_W-1:0] read_addr;
	logic [`F8_WORD_W-1:0] read_data;
	logic [`F8_INST_W-1:0] inst;
	logic [`F8_WORD_W-1:0] mem_operand;
	logic execute;
	logic branch_taken;

	f8_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.reg_write(reg_write),
		.next_flags(next_flags),
		.x(x),
		.y(y),
		.z(),
		.flags(flags)
	);

	f8_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.read_data(read_data),
		.branch_taken(branch_taken),
		.trap(trap),
		.read_addr(read_addr),
		.inst(inst),
		.mem_operand(mem_operand),
		.execute(execute),
		.pc()
	);

	f8_execute u_execute (
		.inst(inst),
		.mem_operand(mem_operand),
		.execute(execute),
		.x(x),
		.y(y),
		.flags(flags),
		.reg_write(reg_write),
		.mem_write(mem_write),
		.next_flags(next_flags),
		.branch_taken(branch_taken),
		.trap(trap)
	);

	f8_bank_mux u_bank_mux (
		.clk(clk),
		.read_addr(read_addr),
		.mem_write(mem_write),
		.read_data_even(read_data_even),
		.read_data_odd(read_data_odd),
		.read_addr_even(read_addr_even),
		.read_addr_odd(read_addr_odd),
		.write_addr_even(write_addr_even),
		.write_addr_odd(write_addr_odd),
		.write_data_even(write_data_even),
		.write_data_odd(write_data_odd),
		.write_en_even(write_en_even),
		.write_en_odd(write_en_odd),
		.read_data(read_data)
	);

endmodule

//--- logic/f8_execute.sv
`include "f8_params.svh"

module f8_execute (
	input logic [`F8_INST_W-1:0] inst,
	input logic [`F8_WORD_W-1:0] mem_operand,
	input logic execute,
	input logic [`F8_WORD_W-1:0] x,
	input logic [`F8_WORD_W-1:0] y,
	input f8_pkg::flags_t flags,
	output f8_pkg::reg_write_t reg_write,
	output f8_pkg::mem_write_t mem_write,
	output f8_pkg::flags_t next_flags,
	output logic branch_taken,
	output logic trap
);
	f8_pkg::opcode_t opcode;
	f8_pkg::alu_op_t alu_op;
	f8_pkg::flags_t alu_flags;
	logic [`F8_DATA_W-1:0] alu_result;

	assign opcode = f8_pkg::opcode_t'(inst[7:0]);

	always_comb
	begin
		case (opcode)
			f8_pkg::OP_SUB_XL_IMMD: alu_op = f8_pkg::ALU_SUB;
			f8_pkg::OP_AND_XL_IMMD: alu_op = f8_pkg::ALU_AND;
			f8_pkg::OP_OR_XL_IMMD: alu_op = f8_pkg::ALU_OR;
			f8_pkg::OP_XOR_XL_IMMD: alu_op = f8_pkg::ALU_XOR;
			default: alu_op = f8_pkg::ALU_ADD;
		endcase
	end

	// xl is always the 8-bit accumulator
	f8_alu8 u_alu8 (
		.op(alu_op),
		.a(x[7:0]),
		.b(inst[15:8]),
		.carry_in_flags(flags),
		.result(alu_result),
		.flags_out(alu_flags)
	);

	always_comb
	begin
		reg_write = '0;
		mem_write = '0;
		next_flags = flags;
		branch_taken = 1'b0;
		trap = 1'b0;
		if (execute)
		begin
			case (opcode)
				f8_pkg::OP_LD_XL_IMMD:
					reg_write = '{en: 2'b01, addr: 2'd0, data: {8'h00, inst[15:8]}};
				f8_pkg::OP_ADD_XL_IMMD, f8_pkg::OP_SUB_XL_IMMD, f8_pkg::OP_AND_XL_IMMD,
				f8_pkg::OP_OR_XL_IMMD, f8_pkg::OP_XOR_XL_IMMD:
				begin
					reg_write = '{en: 2'b01, addr: 2'd0, data: {8'h00, alu_result}};
					next_flags = alu_flags;
				end
				f8_pkg::OP_LD_XL_DIR:
				begin
					reg_write = '{en: 2'b01, addr: 2'd0, data: {8'h00, mem_operand[7:0]}};
					next_flags.z = ~|mem_operand[7:0];
					next_flags.n = mem_operand[7];
				end
				f8_pkg::OP_LD_DIR_XL:
					mem_write = '{en: 2'b01, addr: inst[23:8], data: {8'h00, x[7:0]}};
				f8_pkg::OP_LDW_Y_IMMD:
				begin
					reg_write = '{en: 2'b11, addr: 2'd1, data: inst[23:8]};
					next_flags.z = ~|inst[23:8];
					next_flags.n = inst[23];
				end
				f8_pkg::OP_LDW_DIR_Y:
					mem_write = '{en: 2'b11, addr: inst[23:8], data: y};
				f8_pkg::OP_JR:
					branch_taken = 1'b1;
				f8_pkg::OP_JRZ:
					branch_taken = flags.z;
				f8_pkg::OP_JRNZ:
					branch_taken = !flags.z;
				f8_pkg::OP_JRC:
					branch_taken = flags.c;
				// sequencer holds pc, so trap re-executes every cycle
				f8_pkg::OP_TRAP:
					trap = 1'b1;
				default:
					next_flags = flags;
			endcase
		end
	end

endmodule

//--- logic/f8_params.svh
`ifndef F8_PARAMS_SVH
`define F8_PARAMS_SVH

// byte address and bank word address
`define F8_ADDR_W 16
`define F8_BANK_AW 15

// first fetch address after reset
`define F8_RESET_PC 16'h4000

`define F8_DATA_W 8
`define F8_WORD_W 16

// opcode plus up to two operand bytes
`define F8_INST_W 24

`endif

//--- logic/f8_pkg.sv
`include "f8_params.svh"

package f8_pkg;

	typedef enum logic [7:0] {
		OP_NOP         = 8'h00,
		OP_LD_XL_IMMD  = 8'h01,
		OP_ADD_XL_IMMD = 8'h02,
		OP_SUB_XL_IMMD = 8'h03,
		OP_AND_XL_IMMD = 8'h04,
		OP_OR_XL_IMMD  = 8'h05,
		OP_XOR_XL_IMMD = 8'h06,
		OP_LD_XL_DIR   = 8'h10,
		OP_LD_DIR_XL   = 8'h11,
		OP_LDW_Y_IMMD  = 8'h12,
		OP_LDW_DIR_Y   = 8'h13,
		OP_JR          = 8'h20,
		OP_JRZ         = 8'h21,
		OP_JRNZ        = 8'h22,
		OP_JRC         = 8'h23,
		OP_TRAP        = 8'hff
	} opcode_t;

	typedef struct packed {
		logic o;
		logic z;
		logic n;
		logic c;
		logic h;
	} flags_t;

	// one enable per byte lane
	typedef struct packed {
		logic [1:0] en;
		logic [1:0] addr;
		logic [`F8_WORD_W-1:0] data;
	} reg_write_t;

	typedef struct packed {
		logic [1:0] en;
		logic [`F8_ADDR_W-1:0] addr;
		logic [`F8_WORD_W-1:0] data;
	} mem_write_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

	// unknown opcodes count as one byte
	function automatic logic [1:0] opcode_size(logic [7:0] opcode);
		case (opcode)
			OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD,
			OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC:
				return 2'd2;
			OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_IMMD, OP_LDW_DIR_Y:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

	function automatic logic opcode_reads_mem(logic [7:0] opcode);
		return opcode == OP_LD_XL_DIR;
	endfunction

endpackage

//--- logic/f8_regfile.sv
`include "f8_params.svh"

module f8_regfile (
	input logic clk,
	input logic reset,
	input f8_pkg::reg_write_t reg_write,
	input f8_pkg::flags_t next_flags,
	output logic [`F8_WORD_W-1:0] x,
	output logic [`F8_WORD_W-1:0] y,
	output logic [`F8_WORD_W-1:0] z,
	output f8_pkg::flags_t flags
);
	// index 0 is x, 1 is y, 2 is z
	logic [`F8_WORD_W-1:0] regs [3];

	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];

	always_ff @(posedge clk)
	begin
		if (reg_write.en[0])
			regs[reg_write.addr][7:0] <= reg_write.data[7:0];
		if (reg_write.en[1])
			regs[reg_write.addr][15:8] <= reg_write.data[15:8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	a_no_reg3: assert property (@(posedge clk) disable iff (reset)
		(|reg_write.en) |-> (reg_write.addr != 2'd3))
		else $error("register write addressed index 3");

endmodule

//--- logic/f8_sequencer.sv
`include "f8_params.svh"

module f8_sequencer (
	input logic clk,
	input logic reset,
	input logic [`F8_WORD_W-1:0] read_data,
	input logic branch_taken,
	input logic trap,
	output logic [`F8_ADDR_W-1:0] read_addr,
	output logic [`F8_INST_W-1:0] inst,
	output logic [`F8_WORD_W-1:0] mem_operand,
	output logic execute,
	output logic [`F8_ADDR_W-1:0] pc
);
	logic [`F8_INST_W-1:0] prev_inst;
	logic upper_pending;
	logic operand_pending;
	// low in the first cycle after reset, while the first fetch is in flight
	logic fetch_valid;
	logic [1:0] inst_size;
	logic need_upper;
	logic need_operand;
	logic [`F8_ADDR_W-1:0] next_pc;

	always_comb
	begin
		if (upper_pending)
			inst = {read_data[7:0], prev_inst[15:0]};
		else if (operand_pending)
			inst = prev_inst;
		else
			inst = {8'h00, read_data};
	end

	assign mem_operand = read_data;
	assign inst_size = f8_pkg::opcode_size(inst[7:0]);

	// third byte lives at pc+2, fetched in its own cycle
	assign need_upper = fetch_valid && inst_size == 2'd3 && !upper_pending && !operand_pending;
	assign need_operand = fetch_valid && f8_pkg::opcode_reads_mem(inst[7:0])
		&& !operand_pending && !need_upper;
	assign execute = fetch_valid && !need_upper && !need_operand;

	always_comb
	begin
		if (!execute || trap)
			next_pc = pc;
		else if (branch_taken)
			next_pc = pc + {{8{inst[15]}}, inst[15:8]};
		else
			next_pc = pc + 16'(inst_size);
	end

	always_comb
	begin
		if (need_upper)
			read_addr = pc + 16'd2;
		else if (need_operand)
			read_addr = inst[23:8];
		else
			read_addr = next_pc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= `F8_RESET_PC;
			upper_pending <= 1'b0;
			operand_pending <= 1'b0;
			fetch_valid <= 1'b0;
		end
		else
		begin
			pc <= next_pc;
			upper_pending <= need_upper;
			operand_pending <= need_operand;
			fetch_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		prev_inst <= inst;
	end

	a_one_phase: assert property (@(posedge clk) disable iff (reset)
		!(upper_pending && operand_pending))
		else $error("upper byte and operand fetch pending together");

endmodule

//--- verification/f8_core_tb.sv
`include "f8_params.svh"

module f8_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic reset;
	logic [`F8_BANK_AW-1:0] read_addr_even;
	logic [`F8_BANK_AW-1:0] read_addr_odd;
	logic [`F8_DATA_W-1:0] read_data_even;
	logic [`F8_DATA_W-1:0] read_data_odd;
	logic [`F8_BANK_AW-1:0] write_addr_even;
	logic [`F8_BANK_AW-1:0] write_addr_odd;
	logic [`F8_DATA_W-1:0] write_data_even;
	logic [`F8_DATA_W-1:0] write_data_odd;
	logic write_en_even;
	logic write_en_odd;
	logic trap;

	logic [31:0] lfsr = 32'h47e9_df70;
	logic [7:0] prog [$];
	logic [15:0] exp_addr [$];
	logic [7:0] exp_data [$];
	logic [15:0] pre_addr [$];
	logic [7:0] pre_data [$];
	int n_inst = 0;
	int idx = 0;
	int value_errors = 0;
	int other_errors = 0;
	int slot_even;
	int slot_odd;
	logic odd_first;
	logic even_ok;
	logic odd_ok;
	logic trap_seen;

	f8_core u_dut (.*);

	f8_mem_model u_mem (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic rand_bits(input int n, output logic [31:0] v);
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
	endtask

	task automatic op1(input logic [7:0] op);
		prog.push_back(op);
		n_inst++;
	endtask

	task automatic op2(input logic [7:0] op, input logic [7:0] imm);
		prog.push_back(op);
		prog.push_back(imm);
		n_inst++;
	endtask

	task automatic op3(input logic [7:0] op, input logic [15:0] w);
		prog.push_back(op);
		prog.push_back(w[7:0]);
		prog.push_back(w[15:8]);
		n_inst++;
	endtask

	task automatic expect_write(input logic [15:0] addr, input logic [7:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// store xl to a random address in the data area
	task automatic store_xl(input logic [7:0] acc, input logic expected);
		logic [31:0] r;
		rand_bits(12, r);
		op3(f8_pkg::OP_LD_DIR_XL, 16'h2000 | r[15:0]);
		if (expected)
			expect_write(16'h2000 | r[15:0], acc);
	endtask

	// lower byte address of a two-bank write comes first in the list
	always_comb
	begin
		odd_first = write_en_even && (write_addr_odd < write_addr_even);
		slot_even = idx + (odd_first ? 1 : 0);
		slot_odd = idx + ((write_en_even && !odd_first) ? 1 : 0);
		even_ok = slot_even < exp_addr.size() && exp_addr[slot_even] == {write_addr_even, 1'b0}
			&& exp_data[slot_even] == write_data_even;
		odd_ok = slot_odd < exp_addr.size() && exp_addr[slot_odd] == {write_addr_odd, 1'b1}
			&& exp_data[slot_odd] == write_data_odd;
	end

	always @(posedge clk)
	begin
		if (!reset)
			idx <= idx + int'(write_en_even) + int'(write_en_odd);
	end

	// set from the first trap cycle until reset
	always @(posedge clk)
	begin
		if (reset)
			trap_seen <= 1'b0;
		else if (trap)
			trap_seen <= 1'b1;
	end

	a_even_write: assert property (@(posedge clk) disable iff (reset) write_en_even |-> even_ok)
		else
		begin
			value_errors++;
			$display("Fail %0t: unexpected even bank write %h at byte %h", $time,
				write_data_even, {write_addr_even, 1'b0});
		end

	a_odd_write: assert property (@(posedge clk) disable iff (reset) write_en_odd |-> odd_ok)
		else
		begin
			value_errors++;
			$display("Fail %0t: unexpected odd bank write %h at byte %h", $time,
				write_data_odd, {write_addr_odd, 1'b1});
		end

	a_trap_holds: assert property (@(posedge clk) disable iff (reset) trap |=> trap)
		else
		begin
			other_errors++;
			$display("trap dropped before reset at %0t", $time);
		end

	a_trap_quiet: assert property (@(posedge clk) disable iff (reset)
		(trap || trap_seen) |-> !(write_en_even || write_en_odd))
		else
		begin
			other_errors++;
			$display("memory write seen after trap at %0t", $time);
		end

	initial
	begin
		logic [31:0] r;
		logic [31:0] w;
		logic [7:0] acc;
		logic [7:0] b;
		logic [15:0] d;
		int limit;
		int cycles;
		reset = 1'b1;

		// immediate alu ops with each result stored
		rand_bits(8, r);
		acc = r[7:0];
		op2(f8_pkg::OP_LD_XL_IMMD, acc);
		for (int k = 0; k < 5; k++)
		begin
			rand_bits(8, r);
			b = r[7:0];
			case (k)
				0: op2(f8_pkg::OP_ADD_XL_IMMD, b);
				1: op2(f8_pkg::OP_SUB_XL_IMMD, b);
				2: op2(f8_pkg::OP_AND_XL_IMMD, b);
				3: op2(f8_pkg::OP_OR_XL_IMMD, b);
				default: op2(f8_pkg::OP_XOR_XL_IMMD, b);
			endcase
			case (k)
				0: acc = acc + b;
				1: acc = acc - b;
				2: acc = acc & b;
				3: acc = acc | b;
				default: acc = acc ^ b;
			endcase
			store_xl(acc, 1'b1);
		end

		// word store to an odd address
		rand_bits(16, w);
		op3(f8_pkg::OP_LDW_Y_IMMD, w[15:0]);
		rand_bits(12, r);
		d = 16'h2000 | r[15:0] | 16'h0001;
		op3(f8_pkg::OP_LDW_DIR_Y, d);
		expect_write(d, w[7:0]);
		expect_write(d + 16'd1, w[15:8]);

		// operand read from a preloaded byte
		rand_bits(12, r);
		d = 16'h3000 | r[15:0];
		rand_bits(8, r);
		pre_addr.push_back(d);
		pre_data.push_back(r[7:0]);
		op3(f8_pkg::OP_LD_XL_DIR, d);
		store_xl(r[7:0], 1'b1);

		// jrz skips and jrnz falls through on a zero result
		rand_bits(8, r);
		op2(f8_pkg::OP_LD_XL_IMMD, r[7:0]);
		op2(f8_pkg::OP_SUB_XL_IMMD, r[7:0]);
		op2(f8_pkg::OP_JRZ, 8'd5);
		store_xl(8'h00, 1'b0);
		op2(f8_pkg::OP_JRNZ, 8'd5);
		store_xl(8'h00, 1'b1);

		// jrc skips after an add that carries
		rand_bits(7, r);
		acc = 8'h80 | r[7:0];
		rand_bits(7, r);
		b = 8'h80 | r[7:0];
		op2(f8_pkg::OP_LD_XL_IMMD, acc);
		op2(f8_pkg::OP_ADD_XL_IMMD, b);
		acc = acc + b;
		op2(f8_pkg::OP_JRC, 8'd5);
		store_xl(acc, 1'b0);
		store_xl(acc, 1'b1);
		op1(f8_pkg::OP_TRAP);

		// load after the model fill has run
		@(posedge clk);
		foreach (prog[i])
			u_mem.load_byte(`F8_RESET_PC + 16'(i), prog[i]);
		foreach (pre_addr[i])
			u_mem.load_byte(pre_addr[i], pre_data[i]);
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		limit = 3 * n_inst + 20;
		cycles = 0;
		while (!trap && cycles < limit)
		begin
			@(posedge clk);
			cycles++;
		end
		if (!trap)
		begin
			other_errors++;
			$display("timeout: trap not reached after %0d cycles", cycles);
		end
		else if (idx != exp_addr.size())
		begin
			other_errors++;
			$display("trap rose with %0d writes still expected", exp_addr.size() - idx);
		end
		// a few cycles to watch the trap state
		repeat (8) @(posedge clk);
		$display("errors: %0d wrong value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- verification/f8_mem_model.sv
`include "f8_params.svh"

module f8_mem_model (
	input logic clk,
	input logic [`F8_BANK_AW-1:0] read_addr_even,
	input logic [`F8_BANK_AW-1:0] read_addr_odd,
	output logic [`F8_DATA_W-1:0] read_data_even,
	output logic [`F8_DATA_W-1:0] read_data_odd,
	input logic [`F8_BANK_AW-1:0] write_addr_even,
	input logic [`F8_BANK_AW-1:0] write_addr_odd,
	input logic [`F8_DATA_W-1:0] write_data_even,
	input logic [`F8_DATA_W-1:0] write_data_odd,
	input logic write_en_even,
	input logic write_en_odd
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`F8_DATA_W-1:0] bank_even [2**`F8_BANK_AW];
	logic [`F8_DATA_W-1:0] bank_odd [2**`F8_BANK_AW];

	// fill depends on every address bit
	initial
	begin
		for (int i = 0; i < 2**`F8_BANK_AW; i++)
		begin
			bank_even[i] = 8'(i ^ (i >> 7) ^ (i >> 14)) ^ 8'h5a;
			bank_odd[i] = 8'(i ^ (i >> 7) ^ (i >> 14)) ^ 8'hc3;
		end
	end

	task automatic load_byte(input logic [`F8_ADDR_W-1:0] addr, input logic [7:0] data);
		if (addr[0])
			bank_odd[addr[15:1]] = data;
		else
			bank_even[addr[15:1]] = data;
	endtask

	always @(posedge clk)
	begin
		if (write_en_even)
			bank_even[write_addr_even] <= write_data_even;
		if (write_en_odd)
			bank_odd[write_addr_odd] <= write_data_odd;
		read_data_even <= bank_even[read_addr_even];
		read_data_odd <= bank_odd[read_addr_odd];
	end

endmodule
